// ==== verilog/mempool_pkg.sv ====
/*
 * MemPool system package
 * Address map, data widths, target encoding and request/response formats
 */
package mempool_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8; // One select per byte

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  localparam int unsigned NumCores = 4;

  // L2 memory, word interleaved over the banks
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned L2BankSelWidth = $clog2(NumL2Banks);
  localparam int unsigned L2AddrWidth    = $clog2(NumL2Banks * L2BankNumWords);
  localparam addr_t       L2BaseAddr     = 32'h8000_0000;
  localparam addr_t       L2EndAddr      = 32'h8000_1000; // Exclusive

  // Boot ROM
  localparam int unsigned BootromNumWords  = 64;
  localparam int unsigned BootromAddrWidth = $clog2(BootromNumWords);
  localparam addr_t       BootromBaseAddr  = 32'hA000_0000;
  localparam addr_t       BootromEndAddr   = 32'hA000_00FF; // Inclusive
  localparam logic [15:0] BootromWordTag   = 16'hB007;

  // Control registers, 64 KiB window
  localparam int unsigned CtrlAddrWidth      = 14; // Word address
  localparam addr_t       CtrlBaseAddr       = 32'h4000_0000;
  localparam addr_t       CtrlEndAddr        = 32'h4000_FFFF; // Inclusive
  localparam addr_t       CtrlEocOffset      = 32'h0;
  localparam addr_t       CtrlWakeUpOffset   = 32'h4;
  localparam addr_t       CtrlNumCoresOffset = 32'h8;

  localparam int unsigned FifoDepth = 2;

  typedef enum logic [1:0] {
    TgtL2      = 2'd0,
    TgtBootrom = 2'd1,
    TgtCtrl    = 2'd2
  } target_e;

  typedef struct packed {
    target_e target;
    addr_t   addr;   // Word address inside the target window
    logic    we;
    data_t   wdata;
    strb_t   strb;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } mem_rsp_t;

endpackage : mempool_pkg

// ==== verilog/mem_port_if.sv ====
/*
 * Memory port
 * Request and response streams with valid/ready handshakes
 */
`timescale 1ns/1ps

interface mem_port_if;
  import mempool_pkg::*;

  // Request direction
  logic     req_valid;
  logic     req_ready;
  mem_req_t req;

  // Response direction
  logic     rsp_valid;
  logic     rsp_ready;
  mem_rsp_t rsp;

  modport requester (
    output req_valid, req, rsp_ready,
    input  req_ready, rsp_valid, rsp
  );

  modport responder (
    output req_ready, rsp_valid, rsp,
    input  req_valid, req, rsp_ready
  );

endinterface : mem_port_if

// ==== verilog/wb_host_port.sv ====
/*
 * Wishbone classic host port
 * Decodes the host address, issues one request and answers with ack or err
 */
`timescale 1ns/1ps

module wb_host_port (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  mempool_pkg::addr_t  wb_adr_i,
  input  mempool_pkg::data_t  wb_dat_i,
  input  mempool_pkg::strb_t  wb_sel_i,
  output mempool_pkg::data_t  wb_dat_o,
  output logic                wb_ack_o,
  output logic                wb_err_o,
  mem_port_if.requester       port_o
);
  import mempool_pkg::*;

  typedef enum logic [1:0] {StIdle, StIssue, StWait, StErr} state_e;

  state_e   state_q, state_d;
  logic     strobe;
  logic     hit;
  target_e  hit_tgt;
  addr_t    win_base;
  addr_t    offset;
  mem_req_t req_q;
  logic     rsp_done;

  assign strobe = wb_cyc_i && wb_stb_i;

  // Address decode against the three windows
  always_comb begin
    hit      = 1'b1;
    hit_tgt  = TgtL2;
    win_base = L2BaseAddr;
    if (wb_adr_i >= L2BaseAddr && wb_adr_i < L2EndAddr) begin
      hit_tgt  = TgtL2;
      win_base = L2BaseAddr;
    end else if (wb_adr_i >= BootromBaseAddr && wb_adr_i <= BootromEndAddr) begin
      hit_tgt  = TgtBootrom;
      win_base = BootromBaseAddr;
    end else if (wb_adr_i >= CtrlBaseAddr && wb_adr_i <= CtrlEndAddr) begin
      hit_tgt  = TgtCtrl;
      win_base = CtrlBaseAddr;
    end else begin
      hit = 1'b0; // Unmapped
    end
  end

  assign offset = wb_adr_i - win_base;

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle:  if (strobe) state_d = hit ? StIssue : StErr;
      StIssue: if (port_o.req_ready) state_d = StWait;
      StWait:  if (port_o.rsp_valid) state_d = StIdle;
      default: state_d = StIdle; // Error answer lasts one cycle
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= StIdle;
    else          state_q <= state_d;
  end

  // Request is captured when the strobe is first seen
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && strobe) begin
      req_q.target <= hit_tgt;
      req_q.addr   <= {2'b00, offset[AddrWidth-1:2]};
      req_q.we     <= wb_we_i;
      req_q.wdata  <= wb_dat_i;
      req_q.strb   <= wb_sel_i;
    end
  end

  assign port_o.req_valid = (state_q == StIssue);
  assign port_o.req       = req_q;
  assign port_o.rsp_ready = (state_q == StWait);

  assign rsp_done = port_o.rsp_valid && port_o.rsp_ready;
  assign wb_ack_o = rsp_done && !port_o.rsp.err;
  assign wb_err_o = (state_q == StErr) || (rsp_done && port_o.rsp.err);
  assign wb_dat_o = port_o.rsp.rdata;

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wb_ack_o && wb_err_o));

  // Each access is answered once, never in two cycles back to back
  a_single_answer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o));

endmodule : wb_host_port

// ==== verilog/stream_fifo.sv ====
/*
 * Stream FIFO
 * Circular buffer between two valid/ready streams, payload type is a parameter
 */
`timescale 1ns/1ps

module stream_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = mempool_pkg::FifoDepth
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t              mem_q [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0]   count_q;
  logic                  push, pop;

  assign in_ready_o  = (count_q < CntWidth'(Depth));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)      count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

  // A full FIFO keeps its write side still until something leaves
  a_no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q == CntWidth'(Depth)) && !pop |=>
      (count_q == CntWidth'(Depth)) && (wr_ptr_q == $past(wr_ptr_q)));

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CntWidth'(Depth));

endmodule : stream_fifo

// ==== verilog/l2_mem.sv ====
/*
 * L2 memory
 * Word-interleaved SRAM banks with byte selects, read data one cycle later
 */
`timescale 1ns/1ps

module l2_mem (
  input  logic                                clk_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [mempool_pkg::L2AddrWidth-1:0] addr_i,
  input  mempool_pkg::data_t                  wdata_i,
  input  mempool_pkg::strb_t                  strb_i,
  output mempool_pkg::data_t                  rdata_o
);
  import mempool_pkg::*;

  logic [L2BankSelWidth-1:0]             bank_sel, bank_sel_q;
  logic [L2AddrWidth-L2BankSelWidth-1:0] row;
  data_t [NumL2Banks-1:0]                bank_rdata;

  // Low word address bits pick the bank
  assign bank_sel = addr_i[L2BankSelWidth-1:0];
  assign row      = addr_i[L2AddrWidth-1:L2BankSelWidth];

  for (genvar g = 0; g < NumL2Banks; g++) begin : gen_bank
    data_t mem_q [L2BankNumWords];
    data_t rdata_q;
    logic  bank_req;

    assign bank_req      = req_i && (bank_sel == L2BankSelWidth'(g));
    assign bank_rdata[g] = rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        if (we_i) begin
          for (int b = 0; b < StrbWidth; b++) begin
            if (strb_i[b]) mem_q[row][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end else begin
          rdata_q <= mem_q[row];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) bank_sel_q <= bank_sel; // Bank that answers next cycle
  end

  assign rdata_o = bank_rdata[bank_sel_q];

endmodule : l2_mem

// ==== verilog/bootrom.sv ====
/*
 * Boot ROM
 * Read-only words built from a fixed tag and the word index
 */
`timescale 1ns/1ps

module bootrom (
  input  logic                                     clk_i,
  input  logic                                     req_i,
  input  logic [mempool_pkg::BootromAddrWidth-1:0] addr_i,
  output mempool_pkg::data_t                       rdata_o
);
  import mempool_pkg::*;

  data_t rom_word;
  data_t rdata_q;

  // Tag in the upper half, index in the lower half
  assign rom_word = {BootromWordTag, 16'(addr_i)};

  always_ff @(posedge clk_i) begin
    if (req_i) rdata_q <= rom_word;
  end

  assign rdata_o = rdata_q;

endmodule : bootrom

// ==== verilog/ctrl_regs.sv ====
/*
 * Control registers
 * End-of-computation flag, wake-up pulse and read-only core count
 */
`timescale 1ns/1ps

module ctrl_regs (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [mempool_pkg::CtrlAddrWidth-1:0] addr_i,
  input  mempool_pkg::data_t                    wdata_i,
  output mempool_pkg::data_t                    rdata_o,
  output logic                                  eoc_valid_o,
  output logic [mempool_pkg::NumCores-1:0]      wake_up_o
);
  import mempool_pkg::*;

  logic [CtrlAddrWidth+1:0] byte_off;
  logic                     sel_eoc, sel_wake, sel_cores;
  data_t                    eoc_q;
  logic [NumCores-1:0]      wake_up_q;
  data_t                    rdata_q;

  assign byte_off  = {addr_i, 2'b00};
  assign sel_eoc   = (byte_off == CtrlEocOffset[CtrlAddrWidth+1:0]);
  assign sel_wake  = (byte_off == CtrlWakeUpOffset[CtrlAddrWidth+1:0]);
  assign sel_cores = (byte_off == CtrlNumCoresOffset[CtrlAddrWidth+1:0]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q     <= '0;
      wake_up_q <= '0;
    end else begin
      wake_up_q <= '0; // Pulse lasts one cycle
      if (req_i && we_i) begin
        if (sel_eoc)  eoc_q     <= wdata_i;
        if (sel_wake) wake_up_q <= wdata_i[NumCores-1:0];
      end
    end
  end

  // Read data, wake-up and unused offsets read as zero
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      if (sel_eoc)        rdata_q <= eoc_q;
      else if (sel_cores) rdata_q <= data_t'(NumCores);
      else                rdata_q <= '0;
    end
  end

  assign rdata_o     = rdata_q;
  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_up_q;

  a_wake_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|wake_up_o) |=> (wake_up_o == '0));

endmodule : ctrl_regs

// ==== verilog/target_demux.sv ====
/*
 * Target side
 * Steers requests to L2, boot ROM or control registers and forms the response
 */
`timescale 1ns/1ps

module target_demux (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  mem_port_if.responder                      port_i,
  output logic                               eoc_valid_o,
  output logic [mempool_pkg::NumCores-1:0]   wake_up_o
);
  import mempool_pkg::*;

  logic    accept;
  logic    rsp_pending_q;
  target_e tgt_q;
  logic    err_q;
  logic    l2_req, rom_req, ctrl_req;
  data_t   l2_rdata, rom_rdata, ctrl_rdata;
  data_t   rsp_rdata;

  assign port_i.req_ready = !rsp_pending_q; // No new request while a response waits
  assign accept = port_i.req_valid && port_i.req_ready;

  assign l2_req   = accept && (port_i.req.target == TgtL2);
  assign rom_req  = accept && (port_i.req.target == TgtBootrom) && !port_i.req.we;
  assign ctrl_req = accept && (port_i.req.target == TgtCtrl);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i)                                rsp_pending_q <= 1'b0;
    else if (accept)                             rsp_pending_q <= 1'b1;
    else if (port_i.rsp_valid && port_i.rsp_ready) rsp_pending_q <= 1'b0;
  end

  // Pending target and error flag
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tgt_q <= port_i.req.target;
      err_q <= (port_i.req.target == TgtBootrom) && port_i.req.we; // ROM is read only
    end
  end

  always_comb begin
    case (tgt_q)
      TgtL2:      rsp_rdata = l2_rdata;
      TgtBootrom: rsp_rdata = rom_rdata;
      TgtCtrl:    rsp_rdata = ctrl_rdata;
      default:    rsp_rdata = '0;
    endcase
  end

  assign port_i.rsp_valid = rsp_pending_q;
  assign port_i.rsp       = '{rdata: rsp_rdata, err: err_q};

  l2_mem i_l2_mem (
    .clk_i  (clk_i                             ),
    .req_i  (l2_req                            ),
    .we_i   (port_i.req.we                     ),
    .addr_i (port_i.req.addr[L2AddrWidth-1:0]  ),
    .wdata_i(port_i.req.wdata                  ),
    .strb_i (port_i.req.strb                   ),
    .rdata_o(l2_rdata                          )
  );

  bootrom i_bootrom (
    .clk_i  (clk_i                                 ),
    .req_i  (rom_req                               ),
    .addr_i (port_i.req.addr[BootromAddrWidth-1:0] ),
    .rdata_o(rom_rdata                             )
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i                              ),
    .rst_n_i    (rst_n_i                            ),
    .req_i      (ctrl_req                           ),
    .we_i       (port_i.req.we                      ),
    .addr_i     (port_i.req.addr[CtrlAddrWidth-1:0] ),
    .wdata_i    (port_i.req.wdata                   ),
    .rdata_o    (ctrl_rdata                         ),
    .eoc_valid_o(eoc_valid_o                        ),
    .wake_up_o  (wake_up_o                          )
  );

  // Target field comes from the host port decode
  a_valid_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    port_i.req_valid |-> port_i.req.target inside {TgtL2, TgtBootrom, TgtCtrl});

endmodule : target_demux

// ==== verilog/mempool_system.sv ====
/*
 * MemPool system
 * Host port, request and response FIFOs and the target side
 */
`timescale 1ns/1ps

module mempool_system (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  mempool_pkg::addr_t                wb_adr_i,
  input  mempool_pkg::data_t                wb_dat_i,
  input  mempool_pkg::strb_t                wb_sel_i,
  output mempool_pkg::data_t                wb_dat_o,
  output logic                              wb_ack_o,
  output logic                              wb_err_o,
  output logic                              eoc_valid_o,
  output logic [mempool_pkg::NumCores-1:0]  wake_up_o
);
  import mempool_pkg::*;

  mem_port_if host_port ();   // Host side of the FIFOs
  mem_port_if target_port (); // Target side of the FIFOs

  wb_host_port i_wb_host_port (
    .clk_i   (clk_i    ),
    .rst_n_i (rst_n_i  ),
    .wb_cyc_i(wb_cyc_i ),
    .wb_stb_i(wb_stb_i ),
    .wb_we_i (wb_we_i  ),
    .wb_adr_i(wb_adr_i ),
    .wb_dat_i(wb_dat_i ),
    .wb_sel_i(wb_sel_i ),
    .wb_dat_o(wb_dat_o ),
    .wb_ack_o(wb_ack_o ),
    .wb_err_o(wb_err_o ),
    .port_o  (host_port)
  );

  stream_fifo #(.payload_t(mem_req_t)) req_fifo (
    .clk_i      (clk_i                  ),
    .rst_n_i    (rst_n_i                ),
    .in_valid_i (host_port.req_valid    ),
    .in_ready_o (host_port.req_ready    ),
    .in_data_i  (host_port.req          ),
    .out_valid_o(target_port.req_valid  ),
    .out_ready_i(target_port.req_ready  ),
    .out_data_o (target_port.req        )
  );

  // Responses travel back the other way
  stream_fifo #(.payload_t(mem_rsp_t)) rsp_fifo (
    .clk_i      (clk_i                  ),
    .rst_n_i    (rst_n_i                ),
    .in_valid_i (target_port.rsp_valid  ),
    .in_ready_o (target_port.rsp_ready  ),
    .in_data_i  (target_port.rsp        ),
    .out_valid_o(host_port.rsp_valid    ),
    .out_ready_i(host_port.rsp_ready    ),
    .out_data_o (host_port.rsp          )
  );

  target_demux i_target_demux (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .port_i     (target_port),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule : mempool_system

// ==== verification/system_checker.sv ====
/*
 * System checker
 * Reference model of the host-visible behavior that compares every finished access
 */
`timescale 1ns/1ps

module system_checker (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  mempool_pkg::addr_t               wb_adr_i,
  input  mempool_pkg::data_t               wb_dat_i,
  input  mempool_pkg::strb_t               wb_sel_i,
  input  mempool_pkg::data_t               rdata_i,
  input  logic                             ack_i,
  input  logic                             err_i,
  input  logic                             eoc_valid_i,
  input  logic [mempool_pkg::NumCores-1:0] wake_up_i,
  input  logic                             exp_err_i,
  input  logic                             done_i,
  output int                               error_count_o,
  output int                               access_count_o
);
  import mempool_pkg::*;

  data_t               l2_shadow [int unsigned]; // Word index to contents
  data_t               eoc_shadow;
  int                  wake_cycles;              // Pulse cycles since the last answer
  logic [NumCores-1:0] wake_value;
  logic                reset_seen;
  logic                access_ok;

  initial begin
    error_count_o  = 0;
    access_count_o = 0;
    reset_seen     = 1'b0;
  end

  task automatic value_error(input string name, input data_t exp, input data_t act);
    $display("** Error at %0t ns: %s expected 0x%h, actual 0x%h", $time, name, exp, act);
    error_count_o++;
    access_ok = 1'b0;
  endtask

  task automatic fault(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    error_count_o++;
    access_ok = 1'b0;
  endtask

  task automatic finish_access();
    addr_t               off;
    int unsigned         idx;
    data_t               word;
    data_t               exp_data;
    logic                check_data;
    int                  exp_cycles;
    logic [NumCores-1:0] exp_wake;
    access_ok  = 1'b1;
    check_data = 1'b0;
    exp_data   = '0;
    exp_cycles = 0;
    exp_wake   = '0;
    if (exp_err_i && ack_i) fault("access was answered with ack where err was due");
    if (!exp_err_i && err_i) fault("access was answered with err where ack was due");
    if (!exp_err_i && ack_i) begin
      if (wb_adr_i >= L2BaseAddr && wb_adr_i < L2EndAddr) begin
        idx  = (wb_adr_i - L2BaseAddr) >> 2;
        word = l2_shadow.exists(idx) ? l2_shadow[idx] : 'x;
        if (wb_we_i) begin
          for (int b = 0; b < StrbWidth; b++) begin
            if (wb_sel_i[b]) word[8*b +: 8] = wb_dat_i[8*b +: 8]; // Only selected bytes
          end
          l2_shadow[idx] = word;
        end else begin
          exp_data   = word;
          check_data = 1'b1;
        end
      end else if (wb_adr_i >= BootromBaseAddr && wb_adr_i <= BootromEndAddr) begin
        exp_data   = {BootromWordTag, 16'((wb_adr_i - BootromBaseAddr) >> 2)};
        check_data = !wb_we_i;
      end else if (wb_adr_i >= CtrlBaseAddr && wb_adr_i <= CtrlEndAddr) begin
        off        = wb_adr_i - CtrlBaseAddr;
        check_data = !wb_we_i; // Unused offsets read as zero
        if (off == CtrlEocOffset) begin
          if (wb_we_i) eoc_shadow = wb_dat_i;
          else         exp_data   = eoc_shadow;
        end else if (off == CtrlWakeUpOffset && wb_we_i) begin
          exp_wake   = wb_dat_i[NumCores-1:0];
          exp_cycles = (exp_wake != '0) ? 1 : 0;
        end else if (off == CtrlNumCoresOffset) begin
          exp_data = NumCores;
        end
      end
    end
    if (check_data && rdata_i !== exp_data) value_error("wb_dat_o", exp_data, rdata_i);
    if (wake_cycles != exp_cycles) begin
      fault($sformatf("wake_up_o was high for %0d cycles, %0d expected", wake_cycles, exp_cycles));
    end else if (exp_cycles == 1 && wake_value !== exp_wake) begin
      value_error("wake_up_o", data_t'(exp_wake), data_t'(wake_value));
    end
    if (eoc_valid_i !== eoc_shadow[0]) value_error("eoc_valid_o", eoc_shadow[0], eoc_valid_i);
    wake_cycles = 0;
    access_count_o++;
    $display("%0t ns: access %0d, %s 0x%h, %s", $time, access_count_o,
             wb_we_i ? "write" : "read", wb_adr_i, access_ok ? "ok" : "FAILED");
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_shadow  = '0;
      wake_cycles = 0;
      reset_seen  = 1'b0;
    end else begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (ack_i !== 1'b0 || err_i !== 1'b0 || eoc_valid_i !== 1'b0 || wake_up_i !== '0) begin
          fault("an output was not low in the first cycle after reset");
        end
      end
      if (wake_up_i !== '0) begin
        wake_cycles++;
        wake_value = wake_up_i;
      end
      if ((ack_i || err_i) && !(wb_cyc_i && wb_stb_i)) fault("DUT answered with no access open");
      else if (ack_i || err_i) finish_access();
    end
  end

  always @(posedge done_i) begin
    $display("Accesses checked: %0d, errors: %0d", access_count_o, error_count_o);
  end

endmodule : system_checker

// ==== verification/tb_mempool_system.sv ====
/*
 * Testbench for the MemPool system
 * Applies a table of host accesses over Wishbone, the checker compares results
 */
`timescale 1ns/1ps

module tb_mempool_system;
  import mempool_pkg::*;

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 3;

  typedef struct packed {
    logic  we;
    addr_t adr;
    data_t dat;
    strb_t sel;
    logic  rnd;     // Write data comes from the LFSR
    logic  exp_err; // Access must end in err
  } access_t;

  logic                clk_i;
  logic                rst_n_i;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic                wb_we_i;
  addr_t               wb_adr_i;
  data_t               wb_dat_i;
  strb_t               wb_sel_i;
  data_t               wb_dat_o;
  logic                wb_ack_o;
  logic                wb_err_o;
  logic                eoc_valid_o;
  logic [NumCores-1:0] wake_up_o;
  logic                exp_err;
  logic                done;
  int                  error_count;
  int                  access_count;
  logic [15:0]         lfsr_q;
  access_t             accesses [$];

  mempool_system mempool_system_inst (.*);

  system_checker i_system_checker (
    .clk_i         (clk_i       ),
    .rst_n_i       (rst_n_i     ),
    .wb_cyc_i      (wb_cyc_i    ),
    .wb_stb_i      (wb_stb_i    ),
    .wb_we_i       (wb_we_i     ),
    .wb_adr_i      (wb_adr_i    ),
    .wb_dat_i      (wb_dat_i    ),
    .wb_sel_i      (wb_sel_i    ),
    .rdata_i       (wb_dat_o    ),
    .ack_i         (wb_ack_o    ),
    .err_i         (wb_err_o    ),
    .eoc_valid_i   (eoc_valid_o ),
    .wake_up_i     (wake_up_o   ),
    .exp_err_i     (exp_err     ),
    .done_i        (done        ),
    .error_count_o (error_count ),
    .access_count_o(access_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output data_t w);
    for (int i = 0; i < DataWidth; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w[i]   = lfsr_q[0];
    end
  endtask

  task automatic add_access(input logic we, input addr_t adr, input data_t dat,
                            input strb_t sel, input logic rnd, input logic err);
    access_t a;
    a = {we, adr, dat, sel, rnd, err};
    accesses.push_back(a);
  endtask

  task automatic load_table();
    add_access(1'b1, 32'h8000_0000, 32'h0, 4'hF, 1'b1, 1'b0); // Bank 0
    add_access(1'b1, 32'h8000_0004, 32'h0, 4'hF, 1'b1, 1'b0); // Bank 1
    add_access(1'b1, 32'h8000_0008, 32'h0, 4'hF, 1'b1, 1'b0); // Bank 2
    add_access(1'b1, 32'h8000_000C, 32'h0, 4'hF, 1'b1, 1'b0); // Bank 3
    add_access(1'b1, 32'h8000_0FFC, 32'h0, 4'hF, 1'b1, 1'b0); // Last L2 word
    add_access(1'b1, 32'h8000_0004, 32'h0, 4'h5, 1'b1, 1'b0); // Partial writes
    add_access(1'b1, 32'h8000_0008, 32'h0, 4'h8, 1'b1, 1'b0);
    add_access(1'b0, 32'h8000_0000, 32'h0, 4'hF, 1'b0, 1'b0);
    add_access(1'b0, 32'h8000_0004, 32'h0, 4'hF, 1'b0, 1'b0);
    add_access(1'b0, 32'h8000_0008, 32'h0, 4'hF, 1'b0, 1'b0);
    add_access(1'b0, 32'h8000_000C, 32'h0, 4'hF, 1'b0, 1'b0);
    add_access(1'b0, 32'h8000_0FFC, 32'h0, 4'hF, 1'b0, 1'b0);
    add_access(1'b0, 32'hA000_0000, 32'h0, 4'hF, 1'b0, 1'b0); // Boot ROM
    add_access(1'b0, 32'hA000_0024, 32'h0, 4'hF, 1'b0, 1'b0);
    add_access(1'b0, 32'hA000_00FC, 32'h0, 4'hF, 1'b0, 1'b0);
    add_access(1'b1, 32'hA000_0010, 32'h1234_5678, 4'hF, 1'b0, 1'b1); // Read only
    add_access(1'b0, 32'h0000_0000, 32'h0, 4'hF, 1'b0, 1'b1); // Unmapped
    add_access(1'b1, 32'h6000_0000, 32'hDEAD_BEEF, 4'hF, 1'b0, 1'b1);
    add_access(1'b0, 32'h8000_1000, 32'h0, 4'hF, 1'b0, 1'b1); // Just past L2
    add_access(1'b1, 32'h4000_0000, 32'h1, 4'hF, 1'b0, 1'b0); // Raise eoc
    add_access(1'b0, 32'h4000_0000, 32'h0, 4'hF, 1'b0, 1'b0);
    add_access(1'b0, 32'h4000_0008, 32'h0, 4'hF, 1'b0, 1'b0); // Core count
    add_access(1'b1, 32'h4000_0004, 32'h5, 4'hF, 1'b0, 1'b0); // Wake cores 0 and 2
    add_access(1'b0, 32'h4000_0004, 32'h0, 4'hF, 1'b0, 1'b0);
    add_access(1'b1, 32'h4000_0000, 32'h0, 4'hF, 1'b0, 1'b0); // Clear eoc
    add_access(1'b0, 32'h4000_0000, 32'h0, 4'hF, 1'b0, 1'b0);
    add_access(1'b1, 32'h4000_0004, 32'hFFFF_FFFA, 4'hF, 1'b0, 1'b0);
    add_access(1'b0, 32'h4000_0010, 32'h0, 4'hF, 1'b0, 1'b0); // Unused offset
  endtask

  // Holds the access until ack or err, then leaves the bus idle for a cycle
  task automatic apply_access(input access_t a);
    data_t wdata;
    wdata = a.dat;
    if (a.rnd) random_word(wdata);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = a.we;
    wb_adr_i = a.adr;
    wb_dat_i = wdata;
    wb_sel_i = a.sel;
    exp_err  = a.exp_err;
    @(negedge clk_i);
    while (!(wb_ack_o || wb_err_o)) @(negedge clk_i);
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    @(negedge clk_i);
  endtask

  initial begin
    rst_n_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    exp_err  = 1'b0;
    done     = 1'b0;
    lfsr_q   = 16'd20;
    load_table();
    fork
      begin : watchdog
        #((accesses.size() * 20 + ResetCycles) * ClkPeriod);
        $display("Timeout: the DUT did not finish the accesses in time");
        $display("Test failed");
        $finish;
      end
    join_none
    repeat (ResetCycles) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    foreach (accesses[i]) apply_access(accesses[i]);
    done = 1'b1;
    #1;
    if (error_count == 0 && access_count == accesses.size()) begin
      $display("Test passed");
    end else begin
      if (access_count != accesses.size()) begin
        $display("Only %0d of %0d accesses were checked", access_count, accesses.size());
      end
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_mempool_system

// ==== mempool_system.f ====
verilog/mempool_pkg.sv
verilog/mem_port_if.sv
verilog/wb_host_port.sv
verilog/stream_fifo.sv
verilog/l2_mem.sv
verilog/bootrom.sv
verilog/ctrl_regs.sv
verilog/target_demux.sv
verilog/mempool_system.sv
verification/system_checker.sv
verification/tb_mempool_system.sv

// ==== Bender.yml ====
package:
  name: mempool_system

sources:
  - verilog/mempool_pkg.sv
  - verilog/mem_port_if.sv
  - verilog/wb_host_port.sv
  - verilog/stream_fifo.sv
  - verilog/l2_mem.sv
  - verilog/bootrom.sv
  - verilog/ctrl_regs.sv
  - verilog/target_demux.sv
  - verilog/mempool_system.sv
  - target: test
    files:
      - verification/system_checker.sv
      - verification/tb_mempool_system.sv
